/* hw/keyboard_pkg.sv */
package keyboard_pkg;

   ////////////////////////////////////////
   // event codes
   ////////////////////////////////////////

   localparam int event_code_width = 8;   // one decoded event per pulse
   localparam int break_flag_bit   = 7;   // 0 make, 1 break

   // low seven bits carry key index + 1
   // make 0x01..0x11, break 0x81..0x91, anything else ignored

   ////////////////////////////////////////
   // held key bitmap
   ////////////////////////////////////////

   localparam int num_keys = 17;

   localparam int key_1     = 0;   // number keys pick the waveform
   localparam int key_2     = 1;
   localparam int key_3     = 2;
   localparam int key_4     = 3;
   localparam int key_5     = 4;
   localparam int key_6     = 5;
   localparam int key_7     = 6;
   localparam int key_8     = 7;
   localparam int key_f1    = 8;
   localparam int key_f2    = 9;
   localparam int key_n     = 10;
   localparam int key_m     = 11;
   localparam int key_space = 12;
   localparam int key_left  = 13;   // arrows last
   localparam int key_right = 14;
   localparam int key_up    = 15;
   localparam int key_down  = 16;

endpackage

/* hw/scope_pkg.sv */
package scope_pkg;

   ////////////////////////////////////////
   // waveform choice
   ////////////////////////////////////////

   typedef enum logic [1:0]
   {
      wave_sine   = 2'd0,
      wave_cosine = 2'd1,
      wave_square = 2'd2,
      wave_saw    = 2'd3
   } wave_select_t;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   localparam int wave_width  = 12;   // signed two's complement sample
   localparam int scope_width = 8;    // offset binary, top bits of the wave

   // quarter wave magnitude table, mirrored and negated for a full turn
   localparam int quarter_table_depth = 64;

endpackage

/* hw/keyboard_controls.sv */
`timescale 1ns/1ns

module keyboard_controls
(
   input  logic                                        CLK_25MHZ,
   input  logic                                        reset_from_key,
   input  logic                                        event_valid,   // one pulse per event
   input  logic [keyboard_pkg::event_code_width-1:0]   event_code,
   output logic [keyboard_pkg::num_keys-1:0]           held_keys,
   output scope_pkg::wave_select_t                     wave_select
);

   localparam int key_index_width = $clog2(keyboard_pkg::num_keys);

   ////////////////////////////////////////
   // event decode
   ////////////////////////////////////////

   logic [keyboard_pkg::break_flag_bit-1:0] key_code;   // key index + 1
   logic [key_index_width-1:0]              key_index;
   logic                                    is_break;
   logic                                    code_known;
   logic                                    key_event;

   assign key_code  = event_code[keyboard_pkg::break_flag_bit-1:0];
   assign is_break  = event_code[keyboard_pkg::break_flag_bit];
   assign key_index = key_index_width'(key_code - 1'b1);   // only meaningful when known

   // codes 0 and above the last key are dropped
   assign code_known = (key_code != '0) && (key_code <= keyboard_pkg::num_keys);
   assign key_event  = event_valid && code_known;

   ////////////////////////////////////////
   // held bitmap
   ////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
      end
      else if (key_event)
      begin
         held_keys[key_index] <= ~is_break;   // make sets, break clears
      end
   end

   ////////////////////////////////////////
   // waveform latch
   ////////////////////////////////////////

   // only make events of keys 1..4 move it, release keeps the choice
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         wave_select <= scope_pkg::wave_sine;
      end
      else if (key_event && !is_break)
      begin
         case (key_index)
            keyboard_pkg::key_1: wave_select <= scope_pkg::wave_sine;
            keyboard_pkg::key_2: wave_select <= scope_pkg::wave_cosine;
            keyboard_pkg::key_3: wave_select <= scope_pkg::wave_square;
            keyboard_pkg::key_4: wave_select <= scope_pkg::wave_saw;
            default:             wave_select <= wave_select;   // other keys leave it
         endcase
      end
   end

endmodule

/* hw/nco_waveform_gen.sv */
`timescale 1ns/1ns

module nco_waveform_gen
#(
   parameter int phase_width = 32
)
(
   input  logic                                     CLK_25MHZ,
   input  logic                                     reset_from_key,
   input  logic [phase_width-1:0]                   phase_inc,     // added every cycle
   input  scope_pkg::wave_select_t                  wave_select,
   output logic signed [scope_pkg::wave_width-1:0]  wave_sample
);

   localparam int index_width = $clog2(scope_pkg::quarter_table_depth);
   localparam int mag_width   = scope_pkg::wave_width - 1;   // sign comes from phase

   // quarter turn, top two phase bits = 01
   localparam logic [phase_width-1:0] quarter_turn = {2'b01, {(phase_width-2){1'b0}}};

   ////////////////////////////////////////
   // phase accumulator
   ////////////////////////////////////////

   logic [phase_width-1:0] phase;
   logic [phase_width-1:0] cos_phase;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + phase_inc;   // wraps, one full turn per 2^phase_width
      end
   end

   assign cos_phase = phase + quarter_turn;

   ////////////////////////////////////////
   // quarter wave table
   ////////////////////////////////////////

   logic [mag_width-1:0] quarter_rom [0:scope_pkg::quarter_table_depth-1];

   initial
   begin
      $readmemh("hw/sine_quarter.hex", quarter_rom);
   end

   // full turn from the quarter table
   // bit 30 mirrors the index, bit 31 flips the sign
   function automatic logic signed [scope_pkg::wave_width-1:0] sine_of
   (
      input logic [phase_width-1:0] ph
   );
      logic [index_width-1:0] raw_index;
      logic [index_width-1:0] rom_index;
      logic [mag_width-1:0]   magnitude;
      raw_index = ph[phase_width-3 -: index_width];
      rom_index = ph[phase_width-2] ? ~raw_index : raw_index;   // falling quarter
      magnitude = quarter_rom[rom_index];
      if (ph[phase_width-1])
         sine_of = -$signed({1'b0, magnitude});   // lower half turn
      else
         sine_of = $signed({1'b0, magnitude});
   endfunction

   ////////////////////////////////////////
   // four waveforms
   ////////////////////////////////////////

   logic signed [scope_pkg::wave_width-1:0] sin_value;
   logic signed [scope_pkg::wave_width-1:0] cos_value;
   logic signed [scope_pkg::wave_width-1:0] square_value;
   logic signed [scope_pkg::wave_width-1:0] saw_value;

   always_comb
   begin
      sin_value    = sine_of(phase);
      cos_value    = sine_of(cos_phase);   // sine a quarter turn ahead
      square_value = phase[phase_width-1] ? 12'sh800 : 12'sh7ff;   // full scale both ways
      saw_value    = $signed(phase[phase_width-1 -: scope_pkg::wave_width]);
   end

   // registered selection, one cycle from select to sample
   always_ff @(posedge CLK_25MHZ)
   begin
      case (wave_select)
         scope_pkg::wave_sine:   wave_sample <= sin_value;
         scope_pkg::wave_cosine: wave_sample <= cos_value;
         scope_pkg::wave_square: wave_sample <= square_value;
         default:                wave_sample <= saw_value;   // wave_saw
      endcase
   end

endmodule

/* hw/scope_sample_pacer.sv */
`timescale 1ns/1ns

module scope_sample_pacer
#(
   parameter int sample_divide = 70000
)
(
   input  logic                                     CLK_25MHZ,
   input  logic                                     reset_from_key,
   input  logic signed [scope_pkg::wave_width-1:0]  wave_sample,
   input  logic                                     sample_ready,
   output logic                                     sample_valid,
   output logic [scope_pkg::scope_width-1:0]        sample_data
);

   localparam int count_width = $clog2(sample_divide + 1);

   ////////////////////////////////////////
   // tick divider
   ////////////////////////////////////////

   logic [count_width-1:0] tick_count;
   logic                   tick;

   assign tick = (tick_count == '0);   // one cycle in sample_divide

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || tick)
      begin
         tick_count <= count_width'(sample_divide - 1);   // reload
      end
      else
      begin
         tick_count <= tick_count - 1'b1;
      end
   end

   ////////////////////////////////////////
   // one entry output register
   ////////////////////////////////////////

   logic load;
   logic accept;

   assign accept = sample_valid && sample_ready;
   assign load   = tick && (!sample_valid || sample_ready);   // tick into a full register is lost

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         sample_valid <= 1'b0;
      else if (load)
         sample_valid <= 1'b1;   // refill wins over the transfer
      else if (accept)
         sample_valid <= 1'b0;
   end

   // offset binary, sign inverted, top bits kept
   always_ff @(posedge CLK_25MHZ)
   begin
      if (load)
      begin
         sample_data <= {~wave_sample[scope_pkg::wave_width-1],
                         wave_sample[scope_pkg::wave_width-2 -: scope_pkg::scope_width-1]};
      end
   end

endmodule

/* hw/scope_signal_top.sv */
`timescale 1ns/1ns

module scope_signal_top
#(
   parameter int phase_width   = 32,
   parameter int sample_divide = 70000   // about 357 samples per second at 25 MHz
)
(
   input  logic                                        CLK_25MHZ,
   input  logic                                        reset_from_key,
   input  logic                                        event_valid,
   input  logic [keyboard_pkg::event_code_width-1:0]   event_code,
   input  logic [phase_width-1:0]                      phase_inc,
   input  logic                                        sample_ready,
   output logic                                        sample_valid,
   output logic [scope_pkg::scope_width-1:0]           sample_data,
   output logic [keyboard_pkg::num_keys-1:0]           held_keys,
   output scope_pkg::wave_select_t                     wave_select
);

   logic signed [scope_pkg::wave_width-1:0] wave_sample;   // generator to pacer

   ////////////////////////////////////////
   // keys, generator, pacer
   ////////////////////////////////////////

   keyboard_controls keys
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_valid    (event_valid),
      .event_code     (event_code),
      .held_keys      (held_keys),
      .wave_select    (wave_select)
   );

   nco_waveform_gen #(.phase_width(phase_width)) waves
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .wave_select    (wave_select),
      .wave_sample    (wave_sample)
   );

   scope_sample_pacer #(.sample_divide(sample_divide)) pacer
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .wave_sample    (wave_sample),
      .sample_ready   (sample_ready),
      .sample_valid   (sample_valid),
      .sample_data    (sample_data)
   );

endmodule

/* tb/tb_scope_signal_top.sv */
`timescale 1ns/1ns

module tb_scope_signal_top;

   localparam int sample_divide = 16;     // short pacing for simulation
   localparam int phase_width   = 32;
   localparam int cycle_limit   = 6000;   // square test needs about 4200, the rest under 1000

   logic                                      CLK_25MHZ;
   logic                                      reset_from_key;
   logic                                      event_valid;
   logic [keyboard_pkg::event_code_width-1:0] event_code;
   logic [phase_width-1:0]                    phase_inc;
   logic                                      sample_ready;
   logic                                      sample_valid;
   logic [scope_pkg::scope_width-1:0]         sample_data;
   logic [keyboard_pkg::num_keys-1:0]         held_keys;
   scope_pkg::wave_select_t                   wave_select;

   logic [10:0] sine_table [0:scope_pkg::quarter_table_depth-1];   // own copy of the rom
   logic [15:0] lfsr_state;
   int          cycle_count  = 0;
   int          last_capture = 0;   // cycle where the newest sample showed up
   int          sample_cycle = 0;   // capture cycle of the sample last taken
   int          check_count  = 0;
   int          error_count  = 0;

   scope_signal_top #(.phase_width(phase_width), .sample_divide(sample_divide)) UUT
   (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .event_valid    (event_valid),
      .event_code     (event_code),
      .phase_inc      (phase_inc),
      .sample_ready   (sample_ready),
      .sample_valid   (sample_valid),
      .sample_data    (sample_data),
      .held_keys      (held_keys),
      .wave_select    (wave_select)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;   // 40 ns
   end

   always @(posedge CLK_25MHZ)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("Timeout: tests still running after %0d cycles", cycle_count);
         $display("checks %0d, errors %0d", check_count, error_count);
         $display("Something failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
      end
   endtask

   // 16-bit fibonacci, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic int random_bits(input int n);
      int value;
      int i;
      value = 0;
      for (i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);   // one step per bit
         value = (value << 1) | lfsr_state[0];
      end
      return value;
   endfunction

   function automatic logic [7:0] make_code(input int key);
      return 8'(key + 1);
   endfunction

   function automatic logic [7:0] break_code(input int key);
      return make_code(key) | 8'(1 << keyboard_pkg::break_flag_bit);
   endfunction

   // scope counts moved between two samples, top byte of the phase
   function automatic int scope_step();
      return int'(((64'(phase_inc) * sample_divide) >> 24) & 64'd255);
   endfunction

   // pos is phase bits 31..24, sign, mirror, then table index
   function automatic logic [7:0] sine_scope(input logic [7:0] pos);
      int idx;
      int value;
      idx   = pos[6] ? 63 - pos[5:0] : pos[5:0];
      value = pos[7] ? -int'(sine_table[idx]) : int'(sine_table[idx]);
      return 8'((value + 2048) >> 4);   // offset binary
   endfunction

   task automatic next_cycle();
      logic fire;
      logic was_valid;
      fire      = sample_valid && sample_ready;
      was_valid = sample_valid;
      @(posedge CLK_25MHZ);
      #5;   // outputs settled, inputs driven here
      if (sample_valid && (!was_valid || fire))
         last_capture = cycle_count;   // register refilled on this edge
   endtask

   task automatic send_event(input logic [7:0] code);
      event_code  = code;
      event_valid = 1'b1;   // single pulse, no ready
      next_cycle();
      event_valid = 1'b0;
      event_code  = '0;
   endtask

   task automatic take_sample(output logic [7:0] data);
      sample_ready = 1'b1;
      while (!sample_valid)
         next_cycle();
      data         = sample_data;
      sample_cycle = last_capture;
      next_cycle();   // transfer edge
   endtask

   // old select or old increment may still sit in the first few
   task automatic drain_samples(input int count);
      logic [7:0] dropped;
      int k;
      for (k = 0; k < count; k++)
         take_sample(dropped);
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////

   task automatic test_reset_state();
      check_value(sample_valid, 0, "sample_valid after reset");
      check_value(held_keys, 0, "held_keys after reset");
      check_value(wave_select, scope_pkg::wave_sine, "wave_select after reset");
   endtask

   task automatic test_key_tracking();
      int                                order [keyboard_pkg::num_keys];
      logic [keyboard_pkg::num_keys-1:0] expect_keys;
      scope_pkg::wave_select_t           expect_wave;
      logic [47:0]                       junk;
      logic [7:0]                        code;
      int                                pass;
      int                                i;
      int                                j;
      int                                swap;
      junk        = {8'h00, 8'h12, 8'h7f, 8'h80, 8'h92, 8'hff};   // outside both code ranges
      expect_keys = '0;
      expect_wave = scope_pkg::wave_sine;
      for (pass = 0; pass < 2; pass++)
      begin
         for (i = 0; i < keyboard_pkg::num_keys; i++)
            order[i] = i;
         for (i = keyboard_pkg::num_keys - 1; i > 0; i--)
         begin
            j        = random_bits(5) % (i + 1);   // shuffle
            swap     = order[i];
            order[i] = order[j];
            order[j] = swap;
         end
         for (i = 0; i < keyboard_pkg::num_keys; i++)
         begin
            code = (pass == 0) ? make_code(order[i]) : break_code(order[i]);
            send_event(code);
            expect_keys[order[i]] = (pass == 0);
            if (pass == 0 && order[i] < 4)
               expect_wave = scope_pkg::wave_select_t'(order[i]);   // keys 1..4 in wave order
            check_value(held_keys, expect_keys, $sformatf("held_keys after code %02h", code));
            check_value(wave_select, expect_wave, $sformatf("wave_select after code %02h", code));
         end
         for (i = 0; i < 6; i++)
         begin
            send_event(junk[8*i +: 8]);
            check_value(held_keys, expect_keys, $sformatf("unknown code %02h", junk[8*i +: 8]));
            check_value(wave_select, expect_wave, "wave_select after unknown code");
         end
      end
   endtask

   task automatic test_saw_steps();
      logic [7:0] prev;
      logic [7:0] cur;
      int         k;
      phase_inc = 32'h0010_0000;   // 2^20
      send_event(make_code(keyboard_pkg::key_4));
      drain_samples(3);
      take_sample(prev);
      for (k = 0; k < 8; k++)
      begin
         take_sample(cur);
         check_value(cur, 8'(prev + scope_step()), "sawtooth step");
         prev = cur;
      end
   endtask

   task automatic test_square_runs();
      logic [7:0] level;
      logic [7:0] cur;
      int         expect_run;
      int         n;
      int         run_len;
      expect_run = int'(64'h8000_0000 / (64'(phase_inc) * sample_divide));   // half turn
      send_event(make_code(keyboard_pkg::key_3));
      drain_samples(3);
      take_sample(level);
      cur = level;
      n   = 0;
      while (cur == level && n <= expect_run)   // find an edge first
      begin
         take_sample(cur);
         check_value((cur == 8'hff) || (cur == 8'h00), 1, "square level");
         n++;
      end
      check_value(n <= expect_run, 1, "square edge found");
      level   = cur;
      run_len = 1;
      while (cur == level && run_len <= expect_run)
      begin
         take_sample(cur);
         check_value((cur == 8'hff) || (cur == 8'h00), 1, "square level");
         if (cur == level)
            run_len++;
      end
      check_value(run_len, expect_run, "square run length");
   endtask

   task automatic test_sine_cosine();
      logic [7:0] got [8];
      logic       sine_fit [256];    // start positions that explain the sine run
      int         first_cycle [2];   // capture cycle of each run's first sample
      int         shift;
      int         pass;
      int         k;
      int         start;
      int         ok;
      int         found;
      phase_inc = 32'h0400_0000;   // 2^26
      for (pass = 0; pass < 2; pass++)
      begin
         send_event(make_code(pass == 0 ? keyboard_pkg::key_1 : keyboard_pkg::key_2));
         drain_samples(3);
         for (k = 0; k < 8; k++)
         begin
            take_sample(got[k]);
            if (k == 0)
               first_cycle[pass] = sample_cycle;
         end
         // top byte positions moved since the first sine sample
         shift = int'(((64'(phase_inc) * 64'(first_cycle[pass] - first_cycle[0])) >> 24)
                      & 64'd255);
         found = 0;
         for (start = 0; start < 256; start++)
         begin
            ok = (pass == 0) || sine_fit[start];
            for (k = 0; k < 8; k++)   // cosine is a quarter turn, 64 positions, ahead
               if (got[k] != sine_scope(8'(start + shift + pass * 64 + k * scope_step())))
                  ok = 0;
            if (pass == 0)
               sine_fit[start] = ok;
            if (ok)
               found = 1;
         end
         check_value(found, 1, pass == 0 ? "sine samples off table" : "cosine samples off table");
      end
   endtask

   task automatic test_back_pressure();
      logic [7:0] held;
      logic [7:0] got;
      int         held_cycle;
      int         stall_len;
      int         gap;
      int         round;
      int         k;
      phase_inc = 32'h0010_0000;
      send_event(make_code(keyboard_pkg::key_4));
      drain_samples(3);
      for (round = 0; round < 3; round++)
      begin
         stall_len    = 16 + random_bits(5);
         sample_ready = 1'b0;
         while (!sample_valid)
            next_cycle();
         held       = sample_data;
         held_cycle = last_capture;
         for (k = 0; k < stall_len; k++)
         begin
            next_cycle();
            check_value(sample_valid, 1, "sample_valid under stall");
            check_value(sample_data, held, "sample_data under stall");
         end
         take_sample(got);
         check_value(got, held, "held sample accepted");
         take_sample(got);
         gap = last_capture - held_cycle;   // ticks dropped in between
         check_value(gap % sample_divide, 0, "capture off the tick grid");
         check_value(got, 8'(held + scope_step() * (gap / sample_divide)), "sample after stall");
      end
   endtask

   ////////////////////////////////////////
   // sequence
   ////////////////////////////////////////

   initial
   begin
      reset_from_key = 1'b1;
      event_valid    = 1'b0;
      event_code     = '0;
      phase_inc      = '0;   // phase parked at 0 through the key test
      sample_ready   = 1'b0;
      lfsr_state     = 16'd9;
      $readmemh("hw/sine_quarter.hex", sine_table);
      repeat (3) @(posedge CLK_25MHZ);
      #5;
      reset_from_key = 1'b0;
      next_cycle();
      test_reset_state();
      test_key_tracking();
      test_saw_steps();
      test_square_runs();
      test_sine_cosine();
      test_back_pressure();
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* hw/sine_quarter.hex */
// one column, 11-bit magnitude, entry i = 2047 * sin((i + 0.5) * 90 / 64 deg)
019
04B
07E
0B0
0E2
113
145
177
1A8
1D9
20A
23A
26A
29A
2C9
2F8
327
354
382
3AF
3DB
407
432
45C
486
4AF
4D7
4FF
526
54C
571
596
5B9
5DC
5FD
61E
63E
65D
67B
698
6B4
6CF
6E9
701
719
730
745
759
76D
77F
790
79F
7AE
7BB
7C8
7D3
7DC
7E5
7EC
7F3
7F7
7FB
7FE
7FF

/* filelist.f */
hw/keyboard_pkg.sv
hw/scope_pkg.sv
hw/keyboard_controls.sv
hw/nco_waveform_gen.sv
hw/scope_sample_pacer.sv
hw/scope_signal_top.sv
tb/tb_scope_signal_top.sv
